/* compile.f */
rtl/vmask_pkg.sv
rtl/mask_reg_file.sv
rtl/mask_beat_sequencer.sv
rtl/mask_first_bit.sv
rtl/mask_pop_count.sv
rtl/mask_reduce.sv
rtl/vmask_unit.sv
tb/vmask_unit_tb.sv

/* rtl/mask_beat_sequencer.sv */
`timescale 1ns/100ps

module mask_beat_sequencer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cmd_valid,
    input  vmask_pkg::reg_idx_t   cmd_reg,
    input  vmask_pkg::vl_t        cmd_vl,
    input  vmask_pkg::mask_op_e   cmd_op,
    input  vmask_pkg::tag_t       cmd_tag,
    output logic                  busy,
    output vmask_pkg::reg_idx_t   rd_reg,
    output vmask_pkg::beat_idx_t  rd_beat,
    output logic                  beat_valid,
    output vmask_pkg::beat_idx_t  beat_idx,
    output vmask_pkg::mask_beat_t beat_keep,
    output logic                  beat_last,
    output vmask_pkg::mask_op_e   beat_op,
    output vmask_pkg::tag_t       beat_tag
);

    vmask_pkg::seq_state_e state;
    vmask_pkg::beat_idx_t  cnt;

    vmask_pkg::reg_idx_t   job_reg;
    vmask_pkg::vl_t        job_vl;
    vmask_pkg::mask_op_e   job_op;
    vmask_pkg::tag_t       job_tag;
    vmask_pkg::beat_idx_t  job_last;

    vmask_pkg::vl_t        vl_round;
    vmask_pkg::beat_idx_t  cmd_last;
    vmask_pkg::vl_t        beat_base;
    vmask_pkg::mask_beat_t keep;

    logic                  iss_valid;
    logic                  iss_last;
    vmask_pkg::mask_beat_t iss_keep;
    vmask_pkg::mask_op_e   iss_op;
    vmask_pkg::tag_t       iss_tag;

    assign busy = (state == vmask_pkg::SEQ_ISSUE);

    // Number of beats minus one, at least one beat even for vl of zero.
    always_comb begin
        vl_round = cmd_vl + vmask_pkg::vl_t'(vmask_pkg::BEAT_W - 1);
        if (cmd_vl == '0) begin
            cmd_last = '0;
        end else begin
            cmd_last = vmask_pkg::beat_idx_t'((vl_round >> vmask_pkg::BEAT_SHIFT) - 1'b1);
        end
    end

    always_comb begin
        beat_base = vmask_pkg::vl_t'(cnt) << vmask_pkg::BEAT_SHIFT;
        if (job_vl >= beat_base + vmask_pkg::vl_t'(vmask_pkg::BEAT_W)) begin
            keep = '1;
        end else if (job_vl > beat_base) begin
            keep = ~(vmask_pkg::mask_beat_t'('1) << job_vl[vmask_pkg::BEAT_SHIFT-1:0]);
        end else begin
            keep = '0; // Only reached for vl of zero.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= vmask_pkg::SEQ_IDLE;
            cnt        <= '0;
            rd_reg     <= '0;
            rd_beat    <= '0;
            iss_valid  <= 1'b0;
            beat_valid <= 1'b0;
        end else begin
            iss_valid  <= busy;
            beat_valid <= iss_valid;
            case (state)
                vmask_pkg::SEQ_IDLE: begin
                    if (cmd_valid) begin
                        state <= vmask_pkg::SEQ_ISSUE;
                        cnt   <= '0;
                    end
                end
                vmask_pkg::SEQ_ISSUE: begin
                    rd_reg  <= job_reg;
                    rd_beat <= cnt;
                    cnt     <= cnt + 1'b1;
                    if (cnt == job_last) state <= vmask_pkg::SEQ_IDLE;
                end
                default: state <= vmask_pkg::SEQ_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && cmd_valid) begin
            job_reg  <= cmd_reg;
            job_vl   <= cmd_vl;
            job_op   <= cmd_op;
            job_tag  <= cmd_tag;
            job_last <= cmd_last;
        end
        if (busy) begin
            iss_keep <= keep;
            iss_last <= (cnt == job_last);
            iss_op   <= job_op;
            iss_tag  <= job_tag;
        end
        // Delayed one cycle to meet rd_data.
        beat_idx  <= rd_beat;
        beat_keep <= iss_keep;
        beat_last <= iss_last;
        beat_op   <= iss_op;
        beat_tag  <= iss_tag;
    end

endmodule

/* rtl/mask_first_bit.sv */
`timescale 1ns/100ps

module mask_first_bit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  vmask_pkg::mask_beat_t in_beat,
    input  vmask_pkg::beat_idx_t  in_beat_idx,
    output vmask_pkg::elem_idx_t  out_idx,
    output logic                  out_found
);

    logic [vmask_pkg::BEAT_SHIFT-1:0] bit_pos;
    logic                             any_set;
    vmask_pkg::elem_idx_t             elem_idx;

    // Scan from the top so the lowest set bit is the one that sticks.
    always_comb begin
        bit_pos = '0;
        for (int i = vmask_pkg::BEAT_W - 1; i >= 0; i--) begin
            if (in_beat[i]) begin
                bit_pos = i[vmask_pkg::BEAT_SHIFT-1:0];
            end
        end
    end

    assign any_set  = |in_beat;

    always_comb begin
        elem_idx = vmask_pkg::elem_idx_t'(in_beat_idx) << vmask_pkg::BEAT_SHIFT;
        elem_idx = elem_idx | vmask_pkg::elem_idx_t'(bit_pos);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_found <= 1'b0;
        end else begin
            out_found <= in_valid & any_set;
        end
    end

    always_ff @(posedge clk) begin
        out_idx <= elem_idx; // Only meaningful with out_found.
    end

endmodule

/* rtl/mask_pop_count.sv */
`timescale 1ns/100ps

module mask_pop_count (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    input  vmask_pkg::mask_beat_t         in_beat,
    output logic [vmask_pkg::BEAT_SHIFT:0] out_count
);

    localparam int W = vmask_pkg::BEAT_W;

    logic [1:0] lvl1 [W/2];
    logic [2:0] lvl2 [W/4];
    logic [3:0] lvl3 [W/8];
    logic [4:0] lvl4 [W/16];
    logic [5:0] lvl5 [W/32];
    logic [vmask_pkg::BEAT_SHIFT:0] sum;

    // Pairwise adder tree, each level one bit wider.
    always_comb begin
        for (int i = 0; i < W/2; i++) begin
            lvl1[i] = {1'b0, in_beat[2*i]} + {1'b0, in_beat[2*i+1]};
        end
        for (int i = 0; i < W/4; i++) begin
            lvl2[i] = {1'b0, lvl1[2*i]} + {1'b0, lvl1[2*i+1]};
        end
        for (int i = 0; i < W/8; i++) begin
            lvl3[i] = {1'b0, lvl2[2*i]} + {1'b0, lvl2[2*i+1]};
        end
        for (int i = 0; i < W/16; i++) begin
            lvl4[i] = {1'b0, lvl3[2*i]} + {1'b0, lvl3[2*i+1]};
        end
        for (int i = 0; i < W/32; i++) begin
            lvl5[i] = {1'b0, lvl4[2*i]} + {1'b0, lvl4[2*i+1]};
        end
        sum = {1'b0, lvl5[0]} + {1'b0, lvl5[1]};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_count <= '0;
        end else begin
            out_count <= in_valid ? sum : '0;
        end
    end

endmodule

/* rtl/mask_reduce.sv */
`timescale 1ns/100ps

module mask_reduce (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  beat_valid,
    input  vmask_pkg::mask_beat_t beat_data,
    input  vmask_pkg::mask_beat_t beat_keep,
    input  vmask_pkg::beat_idx_t  beat_idx,
    input  logic                  beat_last,
    input  vmask_pkg::mask_op_e   beat_op,
    input  vmask_pkg::tag_t       beat_tag,
    output logic                  result_valid,
    output vmask_pkg::result_t    result,
    output vmask_pkg::tag_t       result_tag
);

    // s0 registers.
    logic                  s0_valid;
    vmask_pkg::mask_beat_t s0_data;
    vmask_pkg::beat_idx_t  s0_idx;
    logic                  s0_last;
    vmask_pkg::mask_op_e   s0_op;
    vmask_pkg::tag_t       s0_tag;

    // s1 outputs and side band.
    vmask_pkg::elem_idx_t             s1_idx;
    logic                             s1_found;
    logic [vmask_pkg::BEAT_SHIFT:0]   s1_count;
    logic                             s1_last;
    vmask_pkg::mask_op_e              s1_op;
    vmask_pkg::tag_t                  s1_tag;

    // s2 accumulators.
    logic                  s2_last;
    vmask_pkg::mask_op_e   s2_op;
    vmask_pkg::tag_t       s2_tag;
    logic                  acc_found;
    vmask_pkg::elem_idx_t  acc_idx;
    vmask_pkg::popc_t      acc_cnt;

    logic                  prev_found;
    vmask_pkg::popc_t      prev_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            s0_valid <= 1'b0;
            s0_last  <= 1'b0;
            s0_data  <= '0;
        end else begin
            s0_valid <= beat_valid;
            s0_last  <= beat_valid & beat_last;
            s0_data  <= beat_valid ? (beat_data & beat_keep) : '0;
        end
    end

    always_ff @(posedge clk) begin
        s0_idx <= beat_idx;
        s0_op  <= beat_op;
        s0_tag <= beat_tag;
    end

    mask_first_bit u_first_bit (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (s0_valid),
        .in_beat     (s0_data),
        .in_beat_idx (s0_idx),
        .out_idx     (s1_idx),
        .out_found   (s1_found)
    );

    mask_pop_count u_pop_count (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (s0_valid),
        .in_beat   (s0_data),
        .out_count (s1_count)
    );

    always_ff @(posedge clk) begin
        s1_op  <= s0_op;
        s1_tag <= s0_tag;
        s2_op  <= s1_op;
        s2_tag <= s1_tag;
    end

    // Start fresh when the job in s2 just ended.
    assign prev_found = s2_last ? 1'b0 : acc_found;
    assign prev_cnt   = s2_last ? '0 : acc_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_last   <= 1'b0;
            s2_last   <= 1'b0;
            acc_found <= 1'b0;
            acc_idx   <= '0;
            acc_cnt   <= '0;
        end else begin
            s1_last   <= s0_last;
            s2_last   <= s1_last;
            acc_found <= prev_found | s1_found;
            acc_cnt   <= prev_cnt + vmask_pkg::popc_t'(s1_count);
            if (!prev_found && s1_found) begin
                acc_idx <= s1_idx; // Beats come in order, first hit wins.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= s2_last;
        end
    end

    always_ff @(posedge clk) begin
        if (s2_last) begin
            result_tag <= s2_tag;
            if (s2_op == vmask_pkg::OP_POPC) begin
                result <= vmask_pkg::result_t'(acc_cnt);
            end else if (acc_found) begin
                result <= vmask_pkg::result_t'(acc_idx);
            end else begin
                result <= '1; // No bit set below vl.
            end
        end
    end

endmodule

/* rtl/mask_reg_file.sv */
`timescale 1ns/100ps

module mask_reg_file (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wr_en,
    input  vmask_pkg::reg_idx_t   wr_reg,
    input  vmask_pkg::beat_idx_t  wr_beat,
    input  vmask_pkg::mask_beat_t wr_data,
    input  vmask_pkg::reg_idx_t   rd_reg,
    input  vmask_pkg::beat_idx_t  rd_beat,
    output vmask_pkg::mask_beat_t rd_data
);

    localparam int WORDS = vmask_pkg::NUM_REGS * vmask_pkg::BEATS;

    // One word per beat, addressed as {reg, beat}.
    vmask_pkg::mask_beat_t mem [WORDS];

    logic [$clog2(WORDS)-1:0] wr_addr;
    logic [$clog2(WORDS)-1:0] rd_addr;

    assign wr_addr = {wr_reg, wr_beat};
    assign rd_addr = {rd_reg, rd_beat};

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Same-cycle write to this beat is not visible until next read.
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* rtl/vmask_pkg.sv */
package vmask_pkg;

    localparam int BEAT_W     = 64;
    localparam int BEATS      = 8;
    localparam int VLEN       = 512;
    localparam int NUM_REGS   = 8;
    localparam int BEAT_SHIFT = 6;

    typedef logic [BEAT_W-1:0]            mask_beat_t;
    typedef logic [$clog2(BEATS)-1:0]     beat_idx_t;
    typedef logic [$clog2(NUM_REGS)-1:0]  reg_idx_t;
    typedef logic [$clog2(VLEN):0]        vl_t;       // 0 to VLEN inclusive.
    typedef logic [$clog2(VLEN)-1:0]      elem_idx_t;
    typedef logic [$clog2(VLEN):0]        popc_t;
    typedef logic [31:0]                  tag_t;
    typedef logic [63:0]                  result_t;

    typedef enum logic {
        OP_POPC  = 1'b0,
        OP_FIRST = 1'b1
    } mask_op_e;

    typedef enum logic {
        SEQ_IDLE  = 1'b0,
        SEQ_ISSUE = 1'b1
    } seq_state_e;

endpackage

/* rtl/vmask_unit.sv */
`timescale 1ns/100ps

module vmask_unit (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wr_en,
    input  vmask_pkg::reg_idx_t   wr_reg,
    input  vmask_pkg::beat_idx_t  wr_beat,
    input  vmask_pkg::mask_beat_t wr_data,
    input  logic                  cmd_valid,
    input  vmask_pkg::reg_idx_t   cmd_reg,
    input  vmask_pkg::vl_t        cmd_vl,
    input  vmask_pkg::mask_op_e   cmd_op,
    input  vmask_pkg::tag_t       cmd_tag,
    output logic                  busy,
    output logic                  result_valid,
    output vmask_pkg::result_t    result,
    output vmask_pkg::tag_t       result_tag
);

    vmask_pkg::reg_idx_t   rd_reg;
    vmask_pkg::beat_idx_t  rd_beat;
    vmask_pkg::mask_beat_t rd_data;

    logic                  beat_valid;
    vmask_pkg::beat_idx_t  beat_idx;
    vmask_pkg::mask_beat_t beat_keep;
    logic                  beat_last;
    vmask_pkg::mask_op_e   beat_op;
    vmask_pkg::tag_t       beat_tag;

    mask_reg_file u_reg_file (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (wr_en),
        .wr_reg  (wr_reg),
        .wr_beat (wr_beat),
        .wr_data (wr_data),
        .rd_reg  (rd_reg),
        .rd_beat (rd_beat),
        .rd_data (rd_data)
    );

    mask_beat_sequencer u_sequencer (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd_reg    (cmd_reg),
        .cmd_vl     (cmd_vl),
        .cmd_op     (cmd_op),
        .cmd_tag    (cmd_tag),
        .busy       (busy),
        .rd_reg     (rd_reg),
        .rd_beat    (rd_beat),
        .beat_valid (beat_valid),
        .beat_idx   (beat_idx),
        .beat_keep  (beat_keep),
        .beat_last  (beat_last),
        .beat_op    (beat_op),
        .beat_tag   (beat_tag)
    );

    mask_reduce u_reduce (
        .clk          (clk),
        .rst          (rst),
        .beat_valid   (beat_valid),
        .beat_data    (rd_data),
        .beat_keep    (beat_keep),
        .beat_idx     (beat_idx),
        .beat_last    (beat_last),
        .beat_op      (beat_op),
        .beat_tag     (beat_tag),
        .result_valid (result_valid),
        .result       (result),
        .result_tag   (result_tag)
    );

endmodule

/* tb/vmask_unit_tb.sv */
`timescale 1ns/100ps

module vmask_unit_tb;

    localparam int CLK_PERIOD     = 100;
    localparam int RESET_CYCLES   = 16;
    localparam int RESULT_TIMEOUT = 100;
    localparam int QUIET_CYCLES   = 40;
    localparam int MAX_TESTS      = 16;

    logic                  clk;
    logic                  rst;
    logic                  wr_en;
    vmask_pkg::reg_idx_t   wr_reg;
    vmask_pkg::beat_idx_t  wr_beat;
    vmask_pkg::mask_beat_t wr_data;
    logic                  cmd_valid;
    vmask_pkg::reg_idx_t   cmd_reg;
    vmask_pkg::vl_t        cmd_vl;
    vmask_pkg::mask_op_e   cmd_op;
    vmask_pkg::tag_t       cmd_tag;
    logic                  busy;
    logic                  result_valid;
    vmask_pkg::result_t    result;
    vmask_pkg::tag_t       result_tag;

    logic [vmask_pkg::VLEN-1:0] shadow [vmask_pkg::NUM_REGS]; // Copy of register contents.

    string                 t_name [MAX_TESTS];
    int                    t_reg  [MAX_TESTS];
    int                    t_vl   [MAX_TESTS];
    vmask_pkg::mask_op_e   t_op   [MAX_TESTS];
    vmask_pkg::tag_t       t_tag  [MAX_TESTS];
    vmask_pkg::result_t    t_exp  [MAX_TESTS];
    int                    n_tests = 0;

    int                    cyc_n = 0;
    int                    rv_cyc  [$];
    vmask_pkg::result_t    rv_data [$];
    vmask_pkg::tag_t       rv_tag  [$];

    int unsigned           seed_ret;
    int                    c;
    int                    r;
    int                    b;
    int                    i;
    int                    e0;
    int                    e0_a;
    int                    e0_b;
    int                    ov_a;
    int                    ov_b;

    vmask_unit u_vmask_unit (
        .clk          (clk),
        .rst          (rst),
        .wr_en        (wr_en),
        .wr_reg       (wr_reg),
        .wr_beat      (wr_beat),
        .wr_data      (wr_data),
        .cmd_valid    (cmd_valid),
        .cmd_reg      (cmd_reg),
        .cmd_vl       (cmd_vl),
        .cmd_op       (cmd_op),
        .cmd_tag      (cmd_tag),
        .busy         (busy),
        .result_valid (result_valid),
        .result       (result),
        .result_tag   (result_tag)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Results are logged at the falling edge, away from the driving edge.
    always @(negedge clk) begin
        cyc_n = cyc_n + 1;
        if (result_valid === 1'b1) begin
            rv_cyc.push_back(cyc_n);
            rv_data.push_back(result);
            rv_tag.push_back(result_tag);
        end
    end

    task automatic stop_on_error();
        $display("Simulation failed");
        $fatal(1);
    endtask

    function automatic int beats_of(input int vl);
        if (vl == 0) begin
            return 1;
        end
        return (vl + vmask_pkg::BEAT_W - 1) / vmask_pkg::BEAT_W;
    endfunction

    // Popcount or lowest set index over the first vl bits.
    function automatic vmask_pkg::result_t reference_result(input int rg, input int vl,
                                                            input vmask_pkg::mask_op_e op);
        int cnt;
        int first;
        int k;
        cnt   = 0;
        first = -1;
        for (k = 0; k < vl; k++) begin
            if (shadow[rg][k]) begin
                cnt++;
                if (first < 0) begin
                    first = k;
                end
            end
        end
        if (op == vmask_pkg::OP_POPC) begin
            return vmask_pkg::result_t'(cnt);
        end else if (first >= 0) begin
            return vmask_pkg::result_t'(first);
        end
        return '1;
    endfunction

    task automatic add_test(input string name, input int rg, input int vl,
                            input vmask_pkg::mask_op_e op);
        t_name[n_tests] = name;
        t_reg[n_tests]  = rg;
        t_vl[n_tests]   = vl;
        t_op[n_tests]   = op;
        t_tag[n_tests]  = 32'h4000_0000 + n_tests * 32'h40;
        t_exp[n_tests]  = reference_result(rg, vl, op);
        n_tests++;
    endtask

    // Returns at the edge where the DUT samples the command.
    task automatic send_cmd(input int idx, output int edge_cyc);
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd_reg   <= vmask_pkg::reg_idx_t'(t_reg[idx]);
        cmd_vl    <= vmask_pkg::vl_t'(t_vl[idx]);
        cmd_op    <= t_op[idx];
        cmd_tag   <= t_tag[idx];
        @(posedge clk);
        cmd_valid <= 1'b0;
        edge_cyc = cyc_n;
    endtask

    task automatic wait_results(input int count, input string name);
        int waited;
        waited = 0;
        while (rv_cyc.size() < count && waited < RESULT_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        assert (rv_cyc.size() >= count) else begin
            $display("Timed out after %0d cycles waiting for result of %s", waited, name);
            stop_on_error();
        end
    endtask

    task automatic check_result(input int idx, input int edge_cyc);
        int lat;
        lat = rv_cyc[0] - edge_cyc - 1;
        assert (rv_data[0] === t_exp[idx]) else begin
            $display("** Error: %s result expected %h actual %h",
                     t_name[idx], t_exp[idx], rv_data[0]);
            stop_on_error();
        end
        assert (rv_tag[0] === t_tag[idx]) else begin
            $display("** Error: %s tag expected %h actual %h", t_name[idx], t_tag[idx], rv_tag[0]);
            stop_on_error();
        end
        assert (lat == beats_of(t_vl[idx]) + 5) else begin
            $display("** Error: %s latency expected %0d actual %0d",
                     t_name[idx], beats_of(t_vl[idx]) + 5, lat);
            stop_on_error();
        end
        void'(rv_cyc.pop_front());
        void'(rv_data.pop_front());
        void'(rv_tag.pop_front());
    endtask

    initial begin
        seed_ret = $urandom(32'ha9cfb7ae);
        rst       <= 1'b1;
        wr_en     <= 1'b0;
        wr_reg    <= '0;
        wr_beat   <= '0;
        wr_data   <= '0;
        cmd_valid <= 1'b0;
        cmd_reg   <= '0;
        cmd_vl    <= '0;
        cmd_op    <= vmask_pkg::OP_POPC;
        cmd_tag   <= '0;

        for (c = 0; c < RESET_CYCLES + 4; c++) begin
            @(posedge clk);
            if (c == RESET_CYCLES - 1) begin
                rst <= 1'b0;
            end
            @(negedge clk);
            assert (busy === 1'b0 && result_valid === 1'b0) else begin
                $display("busy or result_valid not low during or right after reset");
                stop_on_error();
            end
        end

        // Fixed patterns in registers 0 to 2, random data above.
        for (r = 0; r < vmask_pkg::NUM_REGS; r++) begin
            shadow[r] = '0;
            for (b = 0; b < vmask_pkg::BEATS && r > 2; b++) begin
                shadow[r][b*vmask_pkg::BEAT_W +: vmask_pkg::BEAT_W] = {$urandom, $urandom};
            end
        end
        shadow[1][500] = 1'b1;
        shadow[2][130] = 1'b1;
        for (r = 0; r < vmask_pkg::NUM_REGS; r++) begin
            for (b = 0; b < vmask_pkg::BEATS; b++) begin
                @(posedge clk);
                wr_en   <= 1'b1;
                wr_reg  <= vmask_pkg::reg_idx_t'(r);
                wr_beat <= vmask_pkg::beat_idx_t'(b);
                wr_data <= shadow[r][b*vmask_pkg::BEAT_W +: vmask_pkg::BEAT_W];
            end
        end
        @(posedge clk);
        wr_en <= 1'b0;

        add_test("popc_full_r3", 3, 512, vmask_pkg::OP_POPC);
        add_test("popc_64_r4", 4, 64, vmask_pkg::OP_POPC);
        ov_a = n_tests;
        add_test("popc_100_r5", 5, 100, vmask_pkg::OP_POPC);
        add_test("popc_1_r6", 6, 1, vmask_pkg::OP_POPC);
        add_test("popc_333_r7", 7, 333, vmask_pkg::OP_POPC);
        ov_b = n_tests;
        add_test("first_r2", 2, 512, vmask_pkg::OP_FIRST);
        add_test("first_r1_full", 1, 512, vmask_pkg::OP_FIRST);
        add_test("first_r1_tail", 1, 500, vmask_pkg::OP_FIRST);
        add_test("first_r0", 0, 512, vmask_pkg::OP_FIRST);
        add_test("first_100_r5", 5, 100, vmask_pkg::OP_FIRST);
        add_test("popc_vl0", 3, 0, vmask_pkg::OP_POPC);
        add_test("first_vl0", 3, 0, vmask_pkg::OP_FIRST);

        for (i = 0; i < n_tests; i++) begin
            send_cmd(i, e0);
            wait_results(1, t_name[i]);
            check_result(i, e0);
        end

        // Second job enters on the first idle cycle of the sequencer.
        send_cmd(ov_a, e0_a);
        repeat (beats_of(t_vl[ov_a]) - 1) @(posedge clk);
        send_cmd(ov_b, e0_b);
        @(negedge clk);
        assert (busy === 1'b1) else begin
            $display("Second command was not accepted on the first idle cycle");
            stop_on_error();
        end
        @(posedge clk);
        cmd_valid <= 1'b1; // Strobed while busy, must be dropped.
        cmd_tag   <= 32'h7fff_ffc0;
        @(negedge clk);
        assert (busy === 1'b1) else begin
            $display("busy dropped before the extra command was strobed");
            stop_on_error();
        end
        @(posedge clk);
        cmd_valid <= 1'b0;
        wait_results(2, "overlap");
        for (c = 0; c < QUIET_CYCLES; c++) begin
            @(posedge clk);
        end
        assert (rv_cyc.size() == 2) else begin
            $display("A command strobed while busy produced a result");
            stop_on_error();
        end
        check_result(ov_a, e0_a);
        check_result(ov_b, e0_b);

        $display("Simulation passed");
        $finish;
    end

endmodule
